// File: Makefile
VERILATOR ?= verilator
TOP       ?= memSubsystemTb
BUILD_DIR ?= obj_dir
FILE_LIST ?= list.f
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
PASS_MSG  ?= Finished with no errors

SOURCES := $(shell cat $(FILE_LIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: compile
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: list.f
src/memPipePkg.sv
src/exeMemReg.sv
src/memAccess.sv
src/dataRam.sv
src/memWbStage.sv
src/memSubsystem.sv
verif/memSubsystemTb.sv

// File: src/dataRam.sv
// byte-enabled data RAM
`timescale 1ns/1ns

module dataRam #(
    parameter int ramAddrBits = 10
) (
    input  logic                   clk,
    input  logic                   ramEn,
    input  logic [3:0]             ramWe,
    input  logic [ramAddrBits-1:0] ramAddr,
    input  memPipePkg::wordT       ramWdata,
    output memPipePkg::wordT       ramRdata
);

    import memPipePkg::*;

    localparam int Depth = 1 << ramAddrBits;

    wordT mem [Depth];

    // read returns the old word when the same address is written
    always_ff @(posedge clk) begin
        if (ramEn) begin
            ramRdata <= mem[ramAddr];
            for (int i = 0; i < 4; i++) begin
                if (ramWe[i]) begin
                    mem[ramAddr][i*8 +: 8] <= ramWdata[i*8 +: 8];
                end
            end
        end
    end

endmodule

// File: src/exeMemReg.sv
// EXE/MEM pipeline register
`timescale 1ns/1ns

module exeMemReg (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic                  exeValid,
    input  memPipePkg::exeResultT exeResult,
    input  logic                  memFlush,
    output logic                  memValid,
    output memPipePkg::exeResultT memItem
);

    // ########################################
    // valid flag
    // ########################################

    // a flush wins over a strobe in the same cycle
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            memValid <= 1'b0;
        end else if (memFlush) begin
            memValid <= 1'b0;
        end else begin
            memValid <= exeValid; // an idle cycle becomes a bubble
        end
    end

    // ########################################
    // payload
    // ########################################

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            memItem <= '0;
        end else if (memFlush) begin
            memItem <= '0; // flushed slot carries a zero item
        end else begin
            memItem <= exeResult;
        end
    end

endmodule

// File: src/memAccess.sv
// memory access stage
`timescale 1ns/1ns

module memAccess #(
    parameter int ramAddrBits = 10
) (
    input  logic                   memValid,
    input  memPipePkg::exeResultT  memItem,
    output logic                   ramEn,
    output logic [3:0]             ramWe,
    output logic [ramAddrBits-1:0] ramAddr,
    output memPipePkg::wordT       ramWdata,
    output logic                   stageValid,
    output memPipePkg::memResultT  stageItem
);

    import memPipePkg::*;

    logic       preExc;    // code already set by execute
    logic       loadMis;
    logic       storeMis;
    logic       doAccess;
    logic       isMemOp;
    logic [3:0] byteEn;

    assign preExc  = (memItem.exc != excNone);
    assign isMemOp = (memItem.loadType != ldNone) || (memItem.storeType != stNone);

    // ########################################
    // alignment check
    // ########################################

    always_comb begin
        case (memItem.loadType)
            ldHalfS, ldHalfU: loadMis = memItem.aluOut[0];
            ldWord:           loadMis = |memItem.aluOut[1:0];
            default:          loadMis = 1'b0; // byte loads are always aligned
        endcase
        case (memItem.storeType)
            stHalf:  storeMis = memItem.aluOut[0];
            stWord:  storeMis = |memItem.aluOut[1:0];
            default: storeMis = 1'b0;
        endcase
    end

    // only clean items in a valid slot touch the RAM
    assign doAccess = memValid && !preExc && !loadMis && !storeMis;

    // ########################################
    // RAM request
    // ########################################

    always_comb begin
        case (memItem.storeType)
            stByte:  byteEn = 4'b0001 << memItem.aluOut[1:0];
            stHalf:  byteEn = memItem.aluOut[1] ? 4'b1100 : 4'b0011;
            stWord:  byteEn = 4'b1111;
            default: byteEn = 4'b0000;
        endcase
        // the data is copied into every lane, the enables pick the lanes that land
        case (memItem.storeType)
            stByte:  ramWdata = {4{memItem.storeData[7:0]}};
            stHalf:  ramWdata = {2{memItem.storeData[15:0]}};
            default: ramWdata = memItem.storeData;
        endcase
    end

    assign ramEn   = doAccess && isMemOp;
    assign ramWe   = doAccess ? byteEn : 4'b0000;
    assign ramAddr = memItem.aluOut[ramAddrBits+1:2]; // word index, wraps with RAM size

    // ########################################
    // pass to MEM/WB
    // ########################################

    always_comb begin
        stageItem.pc       = memItem.pc;
        stageItem.aluOut   = memItem.aluOut;
        stageItem.hi       = memItem.hi;
        stageItem.lo       = memItem.lo;
        stageItem.loadType = memItem.loadType;
        stageItem.dst      = memItem.dst;
        stageItem.wbSel    = memItem.wbSel;
        stageItem.exc      = memItem.exc;
        stageItem.regWr    = memItem.regWr;
        if (!preExc && loadMis) begin
            stageItem.exc   = excAddrLoad;
            stageItem.regWr = 1'b0;
        end else if (!preExc && storeMis) begin
            stageItem.exc   = excAddrStore;
            stageItem.regWr = 1'b0;
        end
    end

    assign stageValid = memValid;

endmodule

// File: src/memPipePkg.sv
// memory pipeline shared types
package memPipePkg;

    // ########################################
    // plain vector types
    // ########################################

    typedef logic [31:0] wordT;   // data word or byte address
    typedef logic [4:0]  regIdxT; // general register index

    // default RAM depth as a word-address width, 1K words
    localparam int DefRamAddrBits = 10;

    // ########################################
    // operation encodings
    // ########################################

    typedef enum logic [2:0] {
        ldNone,
        ldByteS,
        ldByteU,
        ldHalfS,
        ldHalfU,
        ldWord
    } loadTypeE;

    typedef enum logic [1:0] {
        stNone,
        stByte,
        stHalf,
        stWord
    } storeTypeE;

    // which value reaches the register file
    typedef enum logic [1:0] {
        wbAlu,
        wbMem,
        wbHi,
        wbLo
    } wbSelE;

    // overflow arrives from execute, the address codes are raised here
    typedef enum logic [1:0] {
        excNone,
        excOverflow,
        excAddrLoad,
        excAddrStore
    } excCodeE;

    // ########################################
    // stage payloads
    // ########################################

    typedef struct packed {
        wordT      pc;
        wordT      instr;
        wordT      aluOut;     // effective address for loads and stores
        wordT      storeData;
        wordT      hi;
        wordT      lo;
        loadTypeE  loadType;
        storeTypeE storeType;
        regIdxT    dst;
        logic      regWr;
        wbSelE     wbSel;
        excCodeE   exc;
    } exeResultT;

    // what is left after the RAM access has been issued
    typedef struct packed {
        wordT     pc;
        wordT     aluOut;
        wordT     hi;
        wordT     lo;
        loadTypeE loadType;
        regIdxT   dst;
        logic     regWr;
        wbSelE    wbSel;
        excCodeE  exc;
    } memResultT;

    typedef struct packed {
        wordT    pc;
        regIdxT  dst;
        logic    regWr;
        wordT    data;
        excCodeE exc;
    } wbResultT;

endpackage

// File: src/memSubsystem.sv
// memory pipeline top level
`timescale 1ns/1ns

module memSubsystem #(
    parameter int ramAddrBits = memPipePkg::DefRamAddrBits
) (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic                  exeValid,
    input  memPipePkg::exeResultT exeResult,
    input  logic                  memFlush,
    output logic                  wbValid,
    output memPipePkg::wbResultT  wbResult
);

    import memPipePkg::*;

    logic                   memValid;
    exeResultT              memItem;
    logic                   ramEn;
    logic [3:0]             ramWe;
    logic [ramAddrBits-1:0] ramAddr;
    wordT                   ramWdata;
    wordT                   ramRdata;
    logic                   stageValid;
    memResultT              stageItem;

    exeMemReg uExeMemReg (
        .clk       (clk),
        .arstN     (arstN),
        .exeValid  (exeValid),
        .exeResult (exeResult),
        .memFlush  (memFlush),
        .memValid  (memValid),
        .memItem   (memItem)
    );

    // address check and RAM request, no register in this stage
    memAccess #(
        .ramAddrBits (ramAddrBits)
    ) uMemAccess (
        .memValid   (memValid),
        .memItem    (memItem),
        .ramEn      (ramEn),
        .ramWe      (ramWe),
        .ramAddr    (ramAddr),
        .ramWdata   (ramWdata),
        .stageValid (stageValid),
        .stageItem  (stageItem)
    );

    dataRam #(
        .ramAddrBits (ramAddrBits)
    ) uDataRam (
        .clk      (clk),
        .ramEn    (ramEn),
        .ramWe    (ramWe),
        .ramAddr  (ramAddr),
        .ramWdata (ramWdata),
        .ramRdata (ramRdata)
    );

    memWbStage uMemWbStage (
        .clk        (clk),
        .arstN      (arstN),
        .stageValid (stageValid),
        .stageItem  (stageItem),
        .ramRdata   (ramRdata),
        .wbValid    (wbValid),
        .wbResult   (wbResult)
    );

endmodule

// File: src/memWbStage.sv
// MEM/WB register and writeback select
`timescale 1ns/1ns

module memWbStage (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic                  stageValid,
    input  memPipePkg::memResultT stageItem,
    input  memPipePkg::wordT      ramRdata,
    output logic                  wbValid,
    output memPipePkg::wbResultT  wbResult
);

    import memPipePkg::*;

    memResultT    wbItem;
    logic [7:0]   loadByte;
    logic [15:0]  loadHalf;
    wordT         loadData;
    wordT         selData;

    // ########################################
    // stage register
    // ########################################

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wbValid <= 1'b0;
            wbItem  <= '0;
        end else begin
            wbValid <= stageValid;
            wbItem  <= stageItem;
        end
    end

    // ########################################
    // load extraction
    // ########################################

    // ramRdata lines up with wbItem, both came from the same edge
    assign loadByte = ramRdata[{wbItem.aluOut[1:0], 3'b000} +: 8];
    assign loadHalf = ramRdata[{wbItem.aluOut[1], 4'b0000} +: 16];

    always_comb begin
        case (wbItem.loadType)
            ldByteS: loadData = {{24{loadByte[7]}}, loadByte};
            ldByteU: loadData = {24'd0, loadByte};
            ldHalfS: loadData = {{16{loadHalf[15]}}, loadHalf};
            ldHalfU: loadData = {16'd0, loadHalf};
            ldWord:  loadData = ramRdata;
            default: loadData = '0;
        endcase
    end

    // ########################################
    // writeback select
    // ########################################

    always_comb begin
        case (wbItem.wbSel)
            wbMem:   selData = loadData;
            wbHi:    selData = wbItem.hi;
            wbLo:    selData = wbItem.lo;
            default: selData = wbItem.aluOut;
        endcase
        if (wbItem.exc != excNone) begin
            selData = '0; // excepted items carry no data
        end
    end

    assign wbResult.pc    = wbItem.pc;
    assign wbResult.dst   = wbItem.dst;
    assign wbResult.regWr = wbItem.regWr;
    assign wbResult.data  = selData;
    assign wbResult.exc   = wbItem.exc;

endmodule

// File: verif/memSubsystemTb.sv
// memory pipeline testbench
`timescale 1ns/1ns

module memSubsystemTb;

    import memPipePkg::*;

    localparam int RamAddrBits   = DefRamAddrBits;
    localparam int ModelAddrBits = RamAddrBits + 2; // byte address width of the RAM
    localparam int ModelBytes    = 1 << ModelAddrBits;

    typedef struct packed {
        logic [31:0] issue;
        wbResultT    res;
    } expT;

    logic      clk;
    logic      arstN;
    logic      exeValid;
    exeResultT exeResult;
    logic      memFlush;
    logic      wbValid;
    wbResultT  wbResult;

    logic [7:0]  memModel [ModelBytes];
    expT         expQ [$];
    string       nameQ [$];
    logic [31:0] cycleNo;
    wordT        pcNext;
    int          mismatchCount;
    int          otherCount;

    memSubsystem #(
        .ramAddrBits (RamAddrBits)
    ) u_dut (
        .clk       (clk),
        .arstN     (arstN),
        .exeValid  (exeValid),
        .exeResult (exeResult),
        .memFlush  (memFlush),
        .wbValid   (wbValid),
        .wbResult  (wbResult)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycleNo <= cycleNo + 32'd1;
    end

    // ########################################
    // compare tasks
    // ########################################

    task automatic checkWord(input string name, input memPipePkg::wordT expV,
                             input memPipePkg::wordT actV);
        if (expV !== actV) begin
            mismatchCount++;
            $display("mismatch %s: expected %h, actual %h", name, expV, actV);
        end
    endtask

    task automatic checkIdx(input string name, input memPipePkg::regIdxT expV,
                            input memPipePkg::regIdxT actV);
        if (expV !== actV) begin
            mismatchCount++;
            $display("mismatch %s: expected %0d, actual %0d", name, expV, actV);
        end
    endtask

    task automatic checkExc(input string name, input memPipePkg::excCodeE expV,
                            input memPipePkg::excCodeE actV);
        if (expV !== actV) begin
            mismatchCount++;
            $display("mismatch %s: expected %s, actual %s", name, expV.name(), actV.name());
        end
    endtask

    task automatic checkBit(input string name, input logic expV, input logic actV);
        if (expV !== actV) begin
            mismatchCount++;
            $display("mismatch %s: expected %b, actual %b", name, expV, actV);
        end
    endtask

    // ########################################
    // reference model
    // ########################################

    function automatic logic [7:0] modelByte(input wordT a);
        return memModel[a[ModelAddrBits-1:0]];
    endfunction

    task automatic writeByte(input wordT a, input logic [7:0] v);
        memModel[a[ModelAddrBits-1:0]] = v;
    endtask

    // stores land in the model at issue time and so in the same order as in the RAM
    task automatic expectItem(input exeResultT it, input string nm);
        expT        e;
        wordT       a;
        logic [7:0] b;
        logic [15:0] h;
        logic       loadMis;
        logic       storeMis;
        a           = it.aluOut;
        e.issue     = cycleNo;
        e.res.pc    = it.pc;
        e.res.dst   = it.dst;
        e.res.regWr = it.regWr;
        e.res.exc   = it.exc;
        e.res.data  = '0;
        loadMis  = ((it.loadType == ldHalfS || it.loadType == ldHalfU) && a[0]) ||
                   (it.loadType == ldWord && a[1:0] != 2'b00);
        storeMis = (it.storeType == stHalf && a[0]) ||
                   (it.storeType == stWord && a[1:0] != 2'b00);
        if (it.exc == excNone && loadMis) begin
            e.res.exc   = excAddrLoad;
            e.res.regWr = 1'b0;
        end else if (it.exc == excNone && storeMis) begin
            e.res.exc   = excAddrStore;
            e.res.regWr = 1'b0;
        end
        if (e.res.exc == excNone) begin
            case (it.storeType)
                stByte: writeByte(a, it.storeData[7:0]);
                stHalf: begin
                    writeByte(a, it.storeData[7:0]);
                    writeByte(a + 32'd1, it.storeData[15:8]);
                end
                stWord: begin
                    for (int k = 0; k < 4; k++) begin
                        writeByte(a + 32'(k), it.storeData[k*8 +: 8]);
                    end
                end
                default: ;
            endcase
            b = modelByte(a);
            h = {modelByte(a + 32'd1), modelByte(a)}; // little-endian lanes
            case (it.wbSel)
                wbHi:  e.res.data = it.hi;
                wbLo:  e.res.data = it.lo;
                wbMem: begin
                    case (it.loadType)
                        ldByteS: e.res.data = {{24{b[7]}}, b};
                        ldByteU: e.res.data = {24'd0, b};
                        ldHalfS: e.res.data = {{16{h[15]}}, h};
                        ldHalfU: e.res.data = {16'd0, h};
                        ldWord:  e.res.data = {modelByte(a + 32'd3), modelByte(a + 32'd2), h};
                        default: e.res.data = '0;
                    endcase
                end
                default: e.res.data = a;
            endcase
        end
        expQ.push_back(e);
        nameQ.push_back(nm);
    endtask

    // ########################################
    // stimulus
    // ########################################

    function automatic exeResultT memOp(input storeTypeE st, input loadTypeE ld,
                                        input wordT addr);
        exeResultT it;
        it           = '0;
        it.aluOut    = addr;
        it.storeData = $urandom;
        it.storeType = st;
        it.loadType  = ld;
        it.dst       = 5'd9;
        it.regWr     = (ld != ldNone);
        it.wbSel     = (ld != ldNone) ? wbMem : wbAlu;
        return it;
    endfunction

    // kind 0..2 selects ALU, HI or LO while 3..5 picks a store and anything else a load
    function automatic exeResultT makeItem(input int kind);
        exeResultT it;
        wordT      r;
        wordT      addr;
        it           = '0;
        r            = $urandom;
        it.instr     = $urandom;
        it.storeData = $urandom;
        it.hi        = $urandom;
        it.lo        = $urandom;
        it.aluOut    = $urandom;
        it.dst       = r[4:0];
        it.regWr     = 1'b1;
        addr         = {26'd0, r[10:5]};  // the 64-byte window is filled before the first load
        if (r[13:11] == 3'd0) begin
            addr[15:12] = r[17:14];       // high bits wrap onto the same RAM word
        end
        case (kind)
            0: it.wbSel = wbAlu;
            1: it.wbSel = wbHi;
            2: it.wbSel = wbLo;
            3, 4, 5: begin
                case (r[19:18])
                    2'd0:    it.storeType = stByte;
                    2'd1:    it.storeType = stHalf;
                    default: it.storeType = stWord;
                endcase
                if (r[23:20] != 4'd0) begin
                    addr[0] = (it.storeType == stByte) ? addr[0] : 1'b0;
                    addr[1] = (it.storeType == stWord) ? 1'b0 : addr[1];
                end
                it.aluOut = addr;
                it.regWr  = r[27];
                it.wbSel  = wbAlu;
            end
            default: begin
                case (r[26:24])
                    3'd0:    it.loadType = ldByteS;
                    3'd1:    it.loadType = ldByteU;
                    3'd2:    it.loadType = ldHalfS;
                    3'd3:    it.loadType = ldHalfU;
                    default: it.loadType = ldWord;
                endcase
                if (r[23:20] != 4'd0) begin
                    addr[0] = (it.loadType == ldByteS || it.loadType == ldByteU) ? addr[0] : 1'b0;
                    addr[1] = (it.loadType == ldWord) ? 1'b0 : addr[1];
                end
                it.aluOut = addr;
                it.wbSel  = wbMem;
            end
        endcase
        if (r[31:28] == 4'd0) begin
            it.exc = excOverflow;
        end
        return it;
    endfunction

    task automatic driveItem(input logic valid, input exeResultT it, input logic flush,
                             input string nm);
        exeResultT item;
        item    = it;
        item.pc = pcNext;
        pcNext  = pcNext + 32'd4;
        @(posedge clk);
        #1;
        exeValid  = valid;
        exeResult = item;
        memFlush  = flush;
        if (valid && !flush) begin
            expectItem(item, nm);
        end
    endtask

    task automatic idleCycles(input int n);
        repeat (n) begin
            driveItem(1'b0, '0, 1'b0, "idle");
        end
    endtask

    // ########################################
    // result checker
    // ########################################

    always @(negedge clk) begin : resultCheck
        expT   e;
        string nm;
        if (expQ.size() > 0 && expQ[0].issue + 32'd2 < cycleNo) begin
            otherCount++;
            $display("no result appeared for the item issued in cycle %0d", expQ[0].issue);
            void'(expQ.pop_front());
            void'(nameQ.pop_front());
        end
        if (wbValid) begin
            if (expQ.size() == 0) begin
                otherCount++;
                $display("wbValid was high in cycle %0d with no item pending", cycleNo);
            end else begin
                e  = expQ.pop_front();
                nm = nameQ.pop_front();
                if (e.issue + 32'd2 != cycleNo) begin
                    otherCount++;
                    $display("the item issued in cycle %0d came out in cycle %0d", e.issue,
                             cycleNo);
                end
                checkWord($sformatf("%s pc", nm), e.res.pc, wbResult.pc);
                checkIdx($sformatf("%s pc %h dst", nm, e.res.pc), e.res.dst, wbResult.dst);
                checkBit($sformatf("%s pc %h regWr", nm, e.res.pc), e.res.regWr, wbResult.regWr);
                checkWord($sformatf("%s pc %h data", nm, e.res.pc), e.res.data, wbResult.data);
                checkExc($sformatf("%s pc %h exc", nm, e.res.pc), e.res.exc, wbResult.exc);
            end
        end
    end

    // ########################################
    // test sequence
    // ########################################

    initial begin
        int        waitCycles;
        int        kind;
        wordT      r;
        exeResultT misStore;
        clk           = 1'b0;
        arstN         = 1'b0;
        exeValid      = 1'b0;
        exeResult     = '0;
        memFlush      = 1'b0;
        cycleNo       = '0;
        pcNext        = 32'h0040_0000;
        mismatchCount = 0;
        otherCount    = 0;
        void'($urandom(16268));
        repeat (16) @(posedge clk);
        #1;
        arstN = 1'b1;
        idleCycles(5); // wbValid must stay low here

        // fill the load window with known words
        for (int k = 0; k < 16; k++) begin
            driveItem(1'b1, memOp(stWord, ldNone, 32'(k) << 2), 1'b0, "fill");
        end
        for (int k = 0; k < 3; k++) begin
            driveItem(1'b1, makeItem(k), 1'b0, "alu hi lo");
        end
        driveItem(1'b1, memOp(stByte, ldNone, 32'h11), 1'b0, "load types");
        driveItem(1'b1, memOp(stNone, ldByteS, 32'h11), 1'b0, "load types");
        driveItem(1'b1, memOp(stNone, ldByteU, 32'h11), 1'b0, "load types");
        driveItem(1'b1, memOp(stNone, ldHalfS, 32'h10), 1'b0, "load types");
        driveItem(1'b1, memOp(stNone, ldHalfU, 32'h12), 1'b0, "load types");
        driveItem(1'b1, memOp(stNone, ldWord, 32'h10), 1'b0, "load types");
        misStore       = memOp(stHalf, ldNone, 32'h5);
        misStore.regWr = 1'b1; // the exception has to clear it
        driveItem(1'b1, misStore, 1'b0, "misaligned store");
        driveItem(1'b1, memOp(stNone, ldWord, 32'h4), 1'b0, "misaligned store");
        driveItem(1'b1, memOp(stNone, ldWord, 32'h2), 1'b0, "misaligned load");
        driveItem(1'b1, memOp(stWord, ldNone, 32'h8), 1'b1, "flushed store");
        driveItem(1'b1, memOp(stNone, ldWord, 32'h8), 1'b0, "flushed store");

        for (int i = 0; i < 600; i++) begin
            r    = $urandom;
            kind = $urandom_range(0, 8);
            driveItem(r[2:0] != 3'd0, makeItem(kind), r[7:4] == 4'd0, "random");
        end
        idleCycles(1);

        waitCycles = 0;
        while (expQ.size() > 0 && waitCycles < 20) begin
            @(posedge clk);
            waitCycles++;
        end
        if (expQ.size() > 0) begin
            otherCount++;
            $display("timed out with %0d results still pending", expQ.size());
        end
        repeat (3) @(negedge clk);

        $display("errors: %0d mismatches, %0d other failures", mismatchCount, otherCount);
        if (mismatchCount + otherCount == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
